// File: bench/tb_soc.sv
// Self-checking testbench that plays the CPU on the fabric's native memory bus
`include "soc_cfg.svh"

module tb_soc
  import soc_pkg::*;
();

  localparam int CLK_PERIOD     = 20;
  localparam int RESET_CYCLES   = 10;
  localparam int MAX_WAIT       = 8;
  localparam int RAM_ACCESSES   = 200;
  localparam int MODE_ACCESSES  = 40;
  localparam int TIMER_LOAD     = 20;
  localparam int TIMER_PRESCALE = 3;
  localparam int TIMER_LIMIT    = (TIMER_LOAD + 1) * (TIMER_PRESCALE + 1) + 8;
  // RAM traffic, trapped and app accesses, readback, and the register tests
  localparam int ACCESS_BUDGET   = RAM_ACCESSES + 2 * MODE_ACCESSES + 32 + 120;
  localparam int WATCHDOG_CYCLES = 4 * RESET_CYCLES + ACCESS_BUDGET * (MAX_WAIT + 2)
                                   + 2 * TIMER_LIMIT + 100;
  localparam logic [31:0] SEED = 32'hc4b79c78;

  localparam logic [31:0] TIMER_BASE    = {`AREA_MMIO, `CORE_TIMER, 24'h0};
  localparam logic [31:0] SYSCTRL_BASE  = {`AREA_MMIO, `CORE_SYSCTRL, 24'h0};
  localparam logic [31:0] RESERVED_ADDR = {`AREA_RESERVED, 30'h0};
  localparam logic [31:0] UNUSED_CORE   = {`AREA_MMIO, 6'h02, 24'h0};

  logic        clk = 1'b0;
  logic        reset_n;
  logic        mem_valid;
  bus_req_t    req;
  logic        mem_ready;
  logic [31:0] mem_rdata;
  logic [2:0]  led;
  logic        app_mode;

  int          errors = 0;
  int          checks = 0;

  // Shadow copies of the first 32 words of each RAM (index 0 fw and 1 app)
  logic [31:0] shadow [2][32];
  logic [3:0]  known [2][32];

  soc_top dut (
    .clk      (clk),
    .reset_n  (reset_n),
    .mem_valid(mem_valid),
    .req      (req),
    .mem_ready(mem_ready),
    .mem_rdata(mem_rdata),
    .led      (led),
    .app_mode (app_mode)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  //----------------------------------------
  // Checking helpers
  //----------------------------------------
  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic confirm(input bit cond, input string what);
    checks++;
    assert (cond) else begin
      errors++;
      $display("Check failed at %0t: %s", $time, what);
    end
  endtask

  //----------------------------------------
  // Bus master
  //----------------------------------------
  // Edges are counted from the first edge that samples the request
  task automatic bus_access(input logic [31:0] addr, input logic [31:0] wdata,
                            input logic [3:0] wstrb, output logic [31:0] rdata,
                            output int edges);
    edges = 0;
    @(posedge clk);
    mem_valid <= 1'b1;
    req       <= '{addr: addr, wdata: wdata, wstrb: wstrb, instr: 1'b0};
    do begin
      @(posedge clk);
      edges++;
      @(negedge clk);
    end while (!mem_ready && edges < MAX_WAIT);
    rdata = mem_rdata;
    confirm(mem_ready, $sformatf("no mem_ready for address %h", addr));
    @(posedge clk);
    mem_valid <= 1'b0;
    req.wstrb <= 4'h0;
  endtask

  task automatic write_word(input logic [31:0] addr, input logic [31:0] data);
    logic [31:0] unused;
    int          edges;
    bus_access(addr, data, 4'hf, unused, edges);
    compare_value("mem_ready latency", 32'(edges), 32'd2);
  endtask

  task automatic read_word(input logic [31:0] addr, output logic [31:0] data);
    int edges;
    bus_access(addr, 32'h0, 4'h0, data, edges);
    compare_value("mem_ready latency", 32'(edges), 32'd2);
  endtask

  //----------------------------------------
  // RAM traffic against the shadow
  //----------------------------------------
  task automatic ram_transfer(input bit app, input int index, input logic [3:0] strb,
                              input logic [31:0] wdata, input bit trapped);
    logic [31:0] addr;
    logic [31:0] rdata;
    logic [31:0] mask;
    int          edges;
    int          slot;
    // Depths are multiples of 32, so a wrapped index lands on the same slot
    slot = index % 32;
    addr = {app ? `AREA_APP : `AREA_FW, 12'h0, 16'(index), 2'b00};
    bus_access(addr, wdata, strb, rdata, edges);
    if (trapped) begin
      compare_value("mem_ready latency", 32'(edges), 32'd1);
      compare_value("mem_rdata", rdata, 32'h0);
    end else begin
      compare_value("mem_ready latency", 32'(edges), 32'd2);
      if (strb == 4'h0) begin
        // Bytes never written are not compared
        for (int b = 0; b < 4; b++) begin
          mask[8*b +: 8] = {8{known[app][slot][b]}};
        end
        compare_value("mem_rdata", rdata & mask, shadow[app][slot] & mask);
      end else begin
        for (int b = 0; b < 4; b++) begin
          if (strb[b]) shadow[app][slot][8*b +: 8] = wdata[8*b +: 8];
        end
        known[app][slot] = known[app][slot] | strb;
      end
    end
  endtask

  task automatic ram_random(input bit app, input bit trapped);
    int         index;
    logic [3:0] strb;
    index = $urandom_range(0, 31);
    if ($urandom_range(0, 1) == 1) index += app ? `APP_RAM_WORDS : `FW_RAM_WORDS;
    strb = ($urandom_range(0, 1) == 1) ? 4'($urandom_range(1, 15)) : 4'h0;
    ram_transfer(app, index, strb, $urandom, trapped);
  endtask

  //----------------------------------------
  // Reset
  //----------------------------------------
  task automatic apply_reset();
    logic [31:0] rdata;
    @(posedge clk);
    reset_n   <= 1'b0;
    mem_valid <= 1'b0;
    req       <= '0;
    repeat (RESET_CYCLES) begin
      @(posedge clk);
      @(negedge clk);
      compare_value("mem_ready", 32'(mem_ready), 32'h0);
      compare_value("mem_rdata", mem_rdata, 32'h0);
      compare_value("led", 32'(led), 32'h0);
      compare_value("app_mode", 32'(app_mode), 32'h0);
    end
    @(posedge clk);
    reset_n <= 1'b1;
    @(posedge clk);
    @(negedge clk);
    compare_value("mem_ready", 32'(mem_ready), 32'h0);
    compare_value("app_mode", 32'(app_mode), 32'h0);
    read_word(TIMER_BASE + 32'h10, rdata);
    compare_value("timer count", rdata, 32'h0);
  endtask

  //----------------------------------------
  // Register level tests
  //----------------------------------------
  task automatic latency_sweep();
    logic [31:0] rdata;
    int          edges;
    read_word({`AREA_FW, 30'h0}, rdata);
    read_word({`AREA_APP, 30'h0}, rdata);
    read_word(TIMER_BASE + 32'h4, rdata);
    read_word(SYSCTRL_BASE, rdata);
    // Read and write the reserved area, then an unused core
    for (int i = 0; i < 4; i++) begin
      bus_access((i < 2) ? RESERVED_ADDR : UNUSED_CORE, $urandom,
                 i[0] ? 4'hf : 4'h0, rdata, edges);
      compare_value("mem_ready latency", 32'(edges), 32'd1);
      compare_value("mem_rdata", rdata, 32'h0);
    end
  endtask

  task automatic timer_countdown();
    logic [31:0] count;
    logic [31:0] status;
    logic [31:0] prev;
    time         start_t;
    int          elapsed;
    write_word(TIMER_BASE + 32'hc, TIMER_LOAD);
    write_word(TIMER_BASE + 32'h8, TIMER_PRESCALE);
    write_word(TIMER_BASE, 32'h1);
    start_t = $time;
    prev    = TIMER_LOAD;
    // Status first, so a nonzero count always follows a running status
    do begin
      read_word(TIMER_BASE + 32'h4, status);
      read_word(TIMER_BASE + 32'h10, count);
      confirm(count <= prev, $sformatf("timer count rose from %0d to %0d", prev, count));
      confirm(count == 0 || status[0], "timer stopped before its count reached 0");
      prev    = count;
      elapsed = int'(($time - start_t) / CLK_PERIOD);
    end while (count != 0 && elapsed <= TIMER_LIMIT);
    confirm(count == 0 && elapsed <= TIMER_LIMIT, "timer did not reach 0 in time");
    repeat (2 * (TIMER_PRESCALE + 1)) @(posedge clk);
    read_word(TIMER_BASE + 32'h10, count);
    compare_value("timer count", count, 32'h0);
    read_word(TIMER_BASE + 32'h4, status);
    compare_value("timer status", status, 32'h0);
  endtask

  task automatic timer_stop();
    logic [31:0] first;
    logic [31:0] second;
    write_word(TIMER_BASE + 32'hc, 32'd1000);
    write_word(TIMER_BASE + 32'h8, 32'h0);
    write_word(TIMER_BASE, 32'h1);
    repeat (10) @(posedge clk);
    write_word(TIMER_BASE, 32'h0);
    read_word(TIMER_BASE + 32'h10, first);
    repeat (10) @(posedge clk);
    read_word(TIMER_BASE + 32'h10, second);
    compare_value("timer count", second, first);
    confirm(first != 0 && first < 1000, "stopped timer count out of range");
    read_word(TIMER_BASE + 32'h4, second);
    compare_value("timer status", second, 32'h0);
  endtask

  task automatic sysctrl_registers();
    logic [31:0] rdata;
    logic [31:0] value;
    read_word(SYSCTRL_BASE, rdata);
    compare_value("sysctrl name", rdata, `SYSCTRL_NAME);
    repeat (4) begin
      value = 32'($urandom_range(0, 7));
      // Upper bits set to show they are dropped
      write_word(SYSCTRL_BASE + 32'h8, value | 32'hffff_fff8);
      @(negedge clk);
      compare_value("led", 32'(led), value);
      read_word(SYSCTRL_BASE + 32'h8, rdata);
      compare_value("led register", rdata, value);
    end
    value = $urandom;
    write_word(SYSCTRL_BASE + 32'hc, value);
    read_word(SYSCTRL_BASE + 32'hc, rdata);
    compare_value("scratch register", rdata, value);
  endtask

  task automatic mode_protection();
    logic [31:0] rdata;
    read_word(SYSCTRL_BASE + 32'h4, rdata);
    compare_value("mode register", rdata, 32'h0);
    // Any write enters application mode even with zero data
    write_word(SYSCTRL_BASE + 32'h4, 32'h0);
    @(negedge clk);
    compare_value("app_mode", 32'(app_mode), 32'h1);
    read_word(SYSCTRL_BASE + 32'h4, rdata);
    compare_value("mode register", rdata, 32'h1);
    repeat (MODE_ACCESSES) ram_random(1'b0, 1'b1);
    repeat (MODE_ACCESSES) ram_random(1'b1, 1'b0);
    write_word(SYSCTRL_BASE + 32'h8, 32'h5);
    @(negedge clk);
    compare_value("led", 32'(led), 32'h5);
  endtask

  //----------------------------------------
  // Main sequence
  //----------------------------------------
  initial begin
    void'($urandom(SEED));
    reset_n    = 1'b0;
    mem_valid  = 1'b0;
    req        = '0;
    for (int s = 0; s < 32; s++) begin
      known[0][s] = 4'h0;
      known[1][s] = 4'h0;
    end

    apply_reset();
    repeat (RAM_ACCESSES) ram_random($urandom_range(0, 1) == 1, 1'b0);
    latency_sweep();
    timer_countdown();
    timer_stop();
    sysctrl_registers();
    mode_protection();

    // Reset leaves application mode and firmware RAM keeps its old contents
    apply_reset();
    for (int i = 0; i < 32; i++) begin
      ram_transfer(1'b0, i, 4'h0, 32'h0, 1'b0);
    end

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Watchdog expired after %0d cycles, the run hung", WATCHDOG_CYCLES);
    $display("*** FAILED ***");
    $finish;
  end

endmodule

// File: include/soc_cfg.svh
// Address map, memory depths and timer width, included by RTL and testbench
`ifndef SOC_CFG_SVH
`define SOC_CFG_SVH

//----------------------------------------
// Area prefixes, addr[31:30]
//----------------------------------------
`define AREA_FW       2'd0
`define AREA_APP      2'd1
`define AREA_RESERVED 2'd2
`define AREA_MMIO     2'd3

//----------------------------------------
// MMIO core prefixes, addr[29:24]
//----------------------------------------
`define CORE_TIMER    6'h01
`define CORE_SYSCTRL  6'h3f

// RAM depths in 32-bit words, powers of two
`define FW_RAM_WORDS  256
`define APP_RAM_WORDS 1024

`define TIMER_WIDTH   32

// ASCII "soc1", returned by sys_ctrl register 0
`define SYSCTRL_NAME  32'h736f6331

`endif

// File: project.f
+incdir+include
rtl/soc_pkg.sv
rtl/bus_decoder.sv
rtl/data_ram.sv
rtl/timer_core.sv
rtl/sys_ctrl.sv
rtl/soc_top.sv
bench/tb_soc.sv

// File: rtl/bus_decoder.sv
// Two-stage address decoder with registered read data and ready back to the bus master
`include "soc_cfg.svh"

module bus_decoder
  import soc_pkg::*;
(
  input  logic        clk,
  input  logic        reset_n,
  input  logic        mem_valid,
  input  bus_req_t    req,
  input  logic        force_trap,
  output core_req_t   fw_req,
  output core_req_t   app_req,
  output core_req_t   timer_req,
  output core_req_t   sysctrl_req,
  input  core_rsp_t   fw_rsp,
  input  core_rsp_t   app_rsp,
  input  core_rsp_t   timer_rsp,
  input  core_rsp_t   sysctrl_rsp,
  output logic        mem_ready,
  output logic [31:0] mem_rdata
);

  logic [1:0]  area;
  logic [5:0]  core;
  core_req_t   ram_base;
  core_req_t   mmio_base;
  logic        ready_new;
  logic [31:0] rdata_new;

  assign area = req.addr[31:30];
  assign core = req.addr[29:24];

  // RAMs take a wide word index and wrap it, MMIO cores only use 8 bits
  assign ram_base  = '{cs: 1'b0, we: req.wstrb, index: req.addr[17:2], wdata: req.wdata};
  assign mmio_base = '{cs: 1'b0, we: req.wstrb, index: {8'h00, req.addr[9:2]},
                       wdata: req.wdata};

  //----------------------------------------
  // Decode and response mux
  //----------------------------------------
  always_comb begin
    fw_req      = ram_base;
    app_req     = ram_base;
    timer_req   = mmio_base;
    sysctrl_req = mmio_base;
    ready_new   = 1'b0;
    rdata_new   = '0;

    // Idle once the registered ready is out, so one access in flight
    if (mem_valid && !mem_ready) begin
      if (force_trap) begin
        // Firmware area locked, never reaches the RAM
        ready_new = 1'b1;
      end else begin
        case (area)
          `AREA_FW: begin
            fw_req.cs = 1'b1;
            rdata_new = fw_rsp.rdata;
            ready_new = fw_rsp.ready;
          end
          `AREA_APP: begin
            app_req.cs = 1'b1;
            rdata_new  = app_rsp.rdata;
            ready_new  = app_rsp.ready;
          end
          `AREA_RESERVED: begin
            ready_new = 1'b1;
          end
          `AREA_MMIO: begin
            case (core)
              `CORE_TIMER: begin
                timer_req.cs = 1'b1;
                rdata_new    = timer_rsp.rdata;
                ready_new    = timer_rsp.ready;
              end
              `CORE_SYSCTRL: begin
                sysctrl_req.cs = 1'b1;
                rdata_new      = sysctrl_rsp.rdata;
                ready_new      = sysctrl_rsp.ready;
              end
              // Undefined core, zero data at once
              default: ready_new = 1'b1;
            endcase
          end
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      mem_ready <= 1'b0;
      mem_rdata <= '0;
    end else begin
      mem_ready <= ready_new;
      mem_rdata <= rdata_new;
    end
  end

endmodule

// File: rtl/data_ram.sv
// Word RAM with byte write strobes and one cycle read latency, used for both RAM areas
module data_ram
  import soc_pkg::*;
#(
  parameter int WORDS = 256
) (
  input  logic      clk,
  input  logic      reset_n,
  input  core_req_t creq,
  output core_rsp_t crsp
);

  // Depth must be a power of two so the index wraps by truncation
  localparam int AW = $clog2(WORDS);

  logic [31:0]   mem [WORDS];
  logic [AW-1:0] word_addr;
  logic [31:0]   rdata_q;
  logic          ready_q;

  assign word_addr = creq.index[AW-1:0];

  //----------------------------------------
  // Storage
  //----------------------------------------
  always_ff @(posedge clk) begin
    if (creq.cs) begin
      for (int i = 0; i < 4; i++) begin
        if (creq.we[i]) begin
          mem[word_addr][8*i +: 8] <= creq.wdata[8*i +: 8];
        end
      end
      // Old contents on a write, ignored by the decoder anyway
      rdata_q <= mem[word_addr];
    end
  end

  // Handshake
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      ready_q <= 1'b0;
    end else begin
      ready_q <= creq.cs;
    end
  end

  assign crsp = '{rdata: rdata_q, ready: ready_q};

endmodule

// File: rtl/soc_pkg.sv
// Bus and per-core request/response types, imported by every fabric module
package soc_pkg;

  //----------------------------------------
  // Master side of the native memory bus
  //----------------------------------------
  // Zero wstrb means a read
  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        instr;
  } bus_req_t;

  //----------------------------------------
  // Decoder to core
  //----------------------------------------
  // One of these per target, cs only on the selected one
  typedef struct packed {
    logic        cs;
    logic [3:0]  we;
    logic [15:0] index;
    logic [31:0] wdata;
  } core_req_t;

  // Core back to decoder
  // ready is cs delayed by one clock
  typedef struct packed {
    logic [31:0] rdata;
    logic        ready;
  } core_rsp_t;

endpackage

// File: rtl/soc_top.sv
// Fabric top level, the bus master drives it in place of the CPU
`include "soc_cfg.svh"

module soc_top
  import soc_pkg::*;
(
  input  logic        clk,
  input  logic        reset_n,
  input  logic        mem_valid,
  input  bus_req_t    req,
  output logic        mem_ready,
  output logic [31:0] mem_rdata,
  output logic [2:0]  led,
  output logic        app_mode
);

  core_req_t fw_req;
  core_req_t app_req;
  core_req_t timer_req;
  core_req_t sysctrl_req;
  core_rsp_t fw_rsp;
  core_rsp_t app_rsp;
  core_rsp_t timer_rsp;
  core_rsp_t sysctrl_rsp;
  logic      force_trap;

  //----------------------------------------
  // Address decode
  //----------------------------------------
  bus_decoder u_decoder (
    .clk        (clk),
    .reset_n    (reset_n),
    .mem_valid  (mem_valid),
    .req        (req),
    .force_trap (force_trap),
    .fw_req     (fw_req),
    .app_req    (app_req),
    .timer_req  (timer_req),
    .sysctrl_req(sysctrl_req),
    .fw_rsp     (fw_rsp),
    .app_rsp    (app_rsp),
    .timer_rsp  (timer_rsp),
    .sysctrl_rsp(sysctrl_rsp),
    .mem_ready  (mem_ready),
    .mem_rdata  (mem_rdata)
  );

  //----------------------------------------
  // Targets
  //----------------------------------------
  data_ram #(.WORDS(`FW_RAM_WORDS)) fw_ram (
    .clk    (clk),
    .reset_n(reset_n),
    .creq   (fw_req),
    .crsp   (fw_rsp)
  );

  data_ram #(.WORDS(`APP_RAM_WORDS)) app_ram (
    .clk    (clk),
    .reset_n(reset_n),
    .creq   (app_req),
    .crsp   (app_rsp)
  );

  timer_core u_timer (
    .clk    (clk),
    .reset_n(reset_n),
    .creq   (timer_req),
    .crsp   (timer_rsp)
  );

  // Sees the raw bus address for the trap check
  sys_ctrl u_sys_ctrl (
    .clk       (clk),
    .reset_n   (reset_n),
    .mem_valid (mem_valid),
    .addr      (req.addr),
    .creq      (sysctrl_req),
    .crsp      (sysctrl_rsp),
    .force_trap(force_trap),
    .app_mode  (app_mode),
    .led       (led)
  );

endmodule

// File: rtl/sys_ctrl.sv
// System controller with one-way application mode, LEDs, scratch and firmware-area trap
`include "soc_cfg.svh"

module sys_ctrl
  import soc_pkg::*;
(
  input  logic        clk,
  input  logic        reset_n,
  input  logic        mem_valid,
  input  logic [31:0] addr,
  input  core_req_t   creq,
  output core_rsp_t   crsp,
  output logic        force_trap,
  output logic        app_mode,
  output logic [2:0]  led
);

  localparam logic [7:0] ADDR_NAME    = 8'h00;
  localparam logic [7:0] ADDR_MODE    = 8'h01;
  localparam logic [7:0] ADDR_LED     = 8'h02;
  localparam logic [7:0] ADDR_SCRATCH = 8'h03;

  logic [7:0]  reg_addr;
  logic        wr;
  logic [31:0] scratch;
  logic [31:0] rdata_q;
  logic        ready_q;

  assign reg_addr = creq.index[7:0];
  assign wr       = creq.cs && (|creq.we);

  // Any firmware-area access from application mode traps
  assign force_trap = app_mode && mem_valid && (addr[31:30] == `AREA_FW);

  //----------------------------------------
  // Control registers
  //----------------------------------------
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      app_mode <= 1'b0;
      led      <= '0;
      ready_q  <= 1'b0;
    end else begin
      ready_q <= creq.cs;
      if (wr) begin
        case (reg_addr)
          // Only reset brings the system back to firmware mode
          ADDR_MODE: app_mode <= 1'b1;
          ADDR_LED:  led      <= creq.wdata[2:0];
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr && (reg_addr == ADDR_SCRATCH)) scratch <= creq.wdata;
  end

  // Read mux
  always_ff @(posedge clk) begin
    if (creq.cs) begin
      case (reg_addr)
        ADDR_NAME:    rdata_q <= `SYSCTRL_NAME;
        ADDR_MODE:    rdata_q <= {31'h0, app_mode};
        ADDR_LED:     rdata_q <= {29'h0, led};
        ADDR_SCRATCH: rdata_q <= scratch;
        default:      rdata_q <= '0;
      endcase
    end
  end

  assign crsp = '{rdata: rdata_q, ready: ready_q};

endmodule

// File: rtl/timer_core.sv
// Prescaled countdown timer on the MMIO bus, started and stopped by register writes
`include "soc_cfg.svh"

module timer_core
  import soc_pkg::*;
(
  input  logic      clk,
  input  logic      reset_n,
  input  core_req_t creq,
  output core_rsp_t crsp
);

  localparam logic [7:0] ADDR_CTRL      = 8'h00;
  localparam logic [7:0] ADDR_STATUS    = 8'h01;
  localparam logic [7:0] ADDR_PRESCALER = 8'h02;
  localparam logic [7:0] ADDR_LOAD      = 8'h03;
  localparam logic [7:0] ADDR_COUNT     = 8'h04;

  logic [7:0]              reg_addr;
  logic                    wr;
  logic                    running;
  logic [`TIMER_WIDTH-1:0] prescaler;
  logic [`TIMER_WIDTH-1:0] load_val;
  logic [`TIMER_WIDTH-1:0] count;
  logic [`TIMER_WIDTH-1:0] pre_cnt;
  logic [31:0]             rdata_q;
  logic                    ready_q;

  assign reg_addr = creq.index[7:0];
  assign wr       = creq.cs && (|creq.we);

  //----------------------------------------
  // Counter and register writes
  //----------------------------------------
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      running   <= 1'b0;
      prescaler <= '0;
      load_val  <= '0;
      count     <= '0;
      pre_cnt   <= '0;
      ready_q   <= 1'b0;
    end else begin
      ready_q <= creq.cs;

      if (running) begin
        if (count == '0) begin
          // Loaded with zero
          running <= 1'b0;
        end else if (pre_cnt == prescaler) begin
          pre_cnt <= '0;
          count   <= count - 1'b1;
          if (count == `TIMER_WIDTH'(1)) running <= 1'b0;
        end else begin
          pre_cnt <= pre_cnt + 1'b1;
        end
      end

      // Bus writes take priority over the tick
      if (wr) begin
        case (reg_addr)
          ADDR_CTRL: begin
            running <= creq.wdata[0];
            if (creq.wdata[0]) begin
              count   <= load_val;
              pre_cnt <= '0;
            end
          end
          ADDR_PRESCALER: prescaler <= creq.wdata[`TIMER_WIDTH-1:0];
          ADDR_LOAD:      load_val  <= creq.wdata[`TIMER_WIDTH-1:0];
          default: ;
        endcase
      end
    end
  end

  // Read mux
  always_ff @(posedge clk) begin
    if (creq.cs) begin
      case (reg_addr)
        ADDR_CTRL, ADDR_STATUS: rdata_q <= {31'h0, running};
        ADDR_PRESCALER:         rdata_q <= 32'(prescaler);
        ADDR_LOAD:              rdata_q <= 32'(load_val);
        ADDR_COUNT:             rdata_q <= 32'(count);
        default:                rdata_q <= '0;
      endcase
    end
  end

  assign crsp = '{rdata: rdata_q, ready: ready_q};

endmodule

// File: run_sim.sh
#!/bin/sh
# Build the fabric testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_soc -f project.f \
  -o tb_soc_sim > build.log 2>&1 || { echo "Verilator build failed, see build.log"; exit 1; }
./obj_dir/tb_soc_sim > sim.log 2>&1 || echo "Simulation exited with nonzero status"
cat sim.log
grep -qF '*** FAILED ***' sim.log && { echo "Simulation failed"; exit 1; }
grep -qF '*** PASSED ***' sim.log || { echo "Run ended without a result"; exit 1; }
echo "Simulation passed"
